/* compile.f */
source/dataPkg.sv
source/accessPkg.sv
source/accessRequest.sv
source/loadAligner.sv
source/storeMerger.sv
source/busSequencer.sv
source/memAccessUnit.sv
testbench/memoryModel.sv
testbench/memAccessUnitTb.sv

/* source/accessPkg.sv */
package accessPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access size and signedness, same codes as the core's MemOp field
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [2:0] memOp_t;

  // bit 2 set means zero extension on a load
  localparam memOp_t OpByte   = 3'b000;
  localparam memOp_t OpHalf   = 3'b001;
  localparam memOp_t OpWord   = 3'b010;
  localparam memOp_t OpDouble = 3'b011;
  localparam memOp_t OpByteU  = 3'b100;
  localparam memOp_t OpHalfU  = 3'b101;
  localparam memOp_t OpWordU  = 3'b110;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus sequencer states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    Idle    = 3'd0,  // waiting for a request
    Read    = 3'd1,  // memRead strobe on the bus
    Capture = 3'd2,  // memReadData valid, results get registered
    Write   = 3'd3,  // memWrite strobe with the merged doubleword
    Finish  = 3'd4   // done pulse, error too if the request was misaligned
  } seqState_t;

endpackage

/* source/accessRequest.sv */
`timescale 1ns/100ps

module accessRequest #(
  parameter int AddrWidth = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 write,
  input  logic [AddrWidth-1:0] addr,
  input  accessPkg::memOp_t    memOp,
  input  dataPkg::doubleWord_t storeData,
  input  logic                 reqRelease,
  output logic [AddrWidth-1:0] reqAddr,
  output accessPkg::memOp_t    reqOp,
  output dataPkg::doubleWord_t reqData,
  output logic                 reqWrite,
  output logic                 pending,
  output logic                 misaligned,
  output logic                 busy
);

  import accessPkg::*;
  import dataPkg::*;

  logic        accept;
  logic        badAlign;
  byteOffset_t lowBits;

  assign accept  = start && !busy;  // a start while busy is simply dropped
  assign lowBits = addr[2:0];

  // halfword needs bit 0 clear, word bits 1:0, doubleword the whole offset
  always_comb begin
    case (memOp)
      OpByte, OpByteU: badAlign = 1'b0;
      OpHalf, OpHalfU: badAlign = lowBits[0];
      OpWord, OpWordU: badAlign = |lowBits[1:0];
      default:         badAlign = |lowBits;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending    <= 1'b0;
      busy       <= 1'b0;
      reqWrite   <= 1'b0;
      misaligned <= 1'b0;
    end else begin
      pending <= accept;                         // one cycle, as the sequencer expects
      if (reqRelease) begin
        busy <= 1'b0;
      end else if (accept) begin
        busy <= 1'b1;
      end
      if (accept) begin
        reqWrite   <= write;
        misaligned <= badAlign;
      end
    end
  end

  // request payload, held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr;
      reqOp   <= memOp;
      reqData <= storeData;
    end
  end

endmodule

/* source/busSequencer.sv */
`timescale 1ns/100ps

module busSequencer #(
  parameter int AddrWidth = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pending,
  input  logic                 misaligned,
  input  logic                 reqWrite,
  input  logic [AddrWidth-1:0] reqAddr,
  output logic [AddrWidth-1:0] memAddr,
  output logic                 memRead,
  output logic                 memWrite,
  output logic                 captureRead,
  output logic                 done,
  output logic                 error,
  output logic                 reqRelease
);

  import accessPkg::*;

  seqState_t state;
  seqState_t nextState;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // every store reads first, doublewords too, so all stores take one path
  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (pending) begin
          nextState = misaligned ? Finish : Read;  // bad alignment skips the bus
        end
      end
      Read: begin
        nextState = Capture;
      end
      Capture: begin
        nextState = reqWrite ? Write : Finish;
      end
      Write: begin
        nextState = Finish;
      end
      Finish: begin
        nextState = Idle;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs, decoded from the state alone
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign memRead     = (state == Read);
  assign captureRead = (state == Capture);  // memory answers the cycle after memRead
  assign memWrite    = (state == Write);
  assign done        = (state == Finish);
  assign error       = (state == Finish) && misaligned;
  assign reqRelease  = done;  // frees the request side in the done cycle

  // bus address is always doubleword aligned
  assign memAddr = {reqAddr[AddrWidth-1:3], 3'b000};

endmodule

/* source/dataPkg.sv */
package dataPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data widths seen on the 64-bit bus and inside the load/store path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [63:0] doubleWord_t;  // one bus beat, also a full register value
  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [7:0]  byte_t;

  // bit n of a mask selects byte lane n, bits [8n+7:8n] of a doubleword
  typedef logic [7:0] byteMask_t;

  typedef logic [2:0] byteOffset_t;   // byte position inside a doubleword

endpackage

/* source/loadAligner.sv */
`timescale 1ns/100ps

module loadAligner (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 captureRead,
  input  dataPkg::byteOffset_t offset,
  input  accessPkg::memOp_t    memOp,
  input  dataPkg::doubleWord_t memReadData,
  output dataPkg::doubleWord_t loadData
);

  import accessPkg::*;
  import dataPkg::*;

  byte_t       byteLane;
  half_t       halfLane;
  word_t       wordLane;
  doubleWord_t extended;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the low offset bits below the access size are ignored here,
  // misaligned requests never reach the capture cycle
  assign byteLane = memReadData[{offset, 3'b000} +: 8];
  assign halfLane = memReadData[{offset[2:1], 4'b0000} +: 16];
  assign wordLane = memReadData[{offset[2], 5'b00000} +: 32];

  always_comb begin
    case (memOp)
      OpByte:  extended = {{56{byteLane[7]}}, byteLane};
      OpByteU: extended = {56'h0, byteLane};
      OpHalf:  extended = {{48{halfLane[15]}}, halfLane};
      OpHalfU: extended = {48'h0, halfLane};
      OpWord:  extended = {{32{wordLane[31]}}, wordLane};
      OpWordU: extended = {32'h0, wordLane};
      default: extended = memReadData;  // doubleword goes through as read
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result register, held for the core until the next capture
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      loadData <= '0;
    end else if (captureRead) begin
      loadData <= extended;
    end
  end

endmodule

/* source/memAccessUnit.sv */
`timescale 1ns/100ps

module memAccessUnit #(
  parameter int AddrWidth = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 write,
  input  logic [AddrWidth-1:0] addr,
  input  accessPkg::memOp_t    memOp,
  input  dataPkg::doubleWord_t storeData,
  input  dataPkg::doubleWord_t memReadData,
  output dataPkg::doubleWord_t loadData,
  output logic                 done,
  output logic                 error,
  output logic                 busy,
  output logic [AddrWidth-1:0] memAddr,
  output logic                 memRead,
  output logic                 memWrite,
  output dataPkg::doubleWord_t memWriteData
);

  import accessPkg::*;
  import dataPkg::*;

  logic [AddrWidth-1:0] reqAddr;
  memOp_t               reqOp;
  doubleWord_t          reqData;
  logic                 reqWrite;
  logic                 pending;
  logic                 misaligned;
  logic                 captureRead;
  logic                 reqRelease;
  byteOffset_t          offset;

  assign offset = reqAddr[2:0];  // byte lane for both processing blocks

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  accessRequest #(
    .AddrWidth(AddrWidth)
  ) request (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .write     (write),
    .addr      (addr),
    .memOp     (memOp),
    .storeData (storeData),
    .reqRelease(reqRelease),
    .reqAddr   (reqAddr),
    .reqOp     (reqOp),
    .reqData   (reqData),
    .reqWrite  (reqWrite),
    .pending   (pending),
    .misaligned(misaligned),
    .busy      (busy)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // load and store data paths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  loadAligner aligner (
    .clk        (clk),
    .reset      (reset),
    .captureRead(captureRead),
    .offset     (offset),
    .memOp      (reqOp),
    .memReadData(memReadData),
    .loadData   (loadData)
  );

  storeMerger merger (
    .clk         (clk),
    .reset       (reset),
    .captureRead (captureRead),
    .offset      (offset),
    .memOp       (reqOp),
    .storeData   (reqData),
    .memReadData (memReadData),
    .memWriteData(memWriteData)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  busSequencer #(
    .AddrWidth(AddrWidth)
  ) sequencer (
    .clk        (clk),
    .reset      (reset),
    .pending    (pending),
    .misaligned (misaligned),
    .reqWrite   (reqWrite),
    .reqAddr    (reqAddr),
    .memAddr    (memAddr),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .captureRead(captureRead),
    .done       (done),
    .error      (error),
    .reqRelease (reqRelease)
  );

endmodule

/* source/storeMerger.sv */
`timescale 1ns/100ps

module storeMerger (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 captureRead,
  input  dataPkg::byteOffset_t offset,
  input  accessPkg::memOp_t    memOp,
  input  dataPkg::doubleWord_t storeData,
  input  dataPkg::doubleWord_t memReadData,
  output dataPkg::doubleWord_t memWriteData
);

  import accessPkg::*;
  import dataPkg::*;

  byteMask_t   laneMask;
  doubleWord_t placed;
  doubleWord_t merged;

  // lanes written by the store, one bit per byte of the doubleword
  always_comb begin
    case (memOp)
      OpByte, OpByteU: laneMask = byteMask_t'(8'h01) << offset;
      OpHalf, OpHalfU: laneMask = byteMask_t'(8'h03) << {offset[2:1], 1'b0};
      OpWord, OpWordU: laneMask = byteMask_t'(8'h0f) << {offset[2], 2'b00};
      default:         laneMask = 8'hff;
    endcase
  end

  // store value moves up so its low byte sits on lane offset
  assign placed = storeData << {offset, 3'b000};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read-modify-write merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    merged = memReadData;  // unmasked lanes keep what memory holds
    for (int lane = 0; lane < 8; lane++) begin
      if (laneMask[lane]) begin
        merged[lane*8 +: 8] = placed[lane*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteData <= '0;
    end else if (captureRead) begin
      memWriteData <= merged;  // on the bus during the Write state
    end
  end

endmodule

/* testbench/memAccessUnitTb.sv */
`timescale 1ns/100ps

module memAccessUnitTb;

  import accessPkg::*;
  import dataPkg::*;

  localparam int ClockPeriod = 100;
  localparam int Depth       = 32;
  localparam int SeedValue   = 32'hc3a9;
  localparam int MaxAccesses = 400;
  localparam int DoneLimit   = 10;  // cycles to wait for done before giving up

  logic        clk;
  logic        reset;
  logic        start;
  logic        write;
  logic [63:0] addr;
  memOp_t      memOp;
  doubleWord_t storeData;
  doubleWord_t memReadData;
  doubleWord_t loadData;
  logic        done;
  logic        error;
  logic        busy;
  logic [63:0] memAddr;
  logic        memRead;
  logic        memWrite;
  doubleWord_t memWriteData;

  integer      seed;
  int          valueErrors = 0;
  int          otherErrors = 0;
  doubleWord_t shadow [Depth];
  memOp_t      opList [7] = '{OpByte, OpHalf, OpWord, OpDouble, OpByteU, OpHalfU, OpWordU};

  // reference state of the access in flight
  logic        inFlight  = 1'b0;
  logic        prevReset = 1'b0;
  int          edgeCount = 0;
  int          acceptEdge;
  int          expLatency;
  logic        expFault;
  logic        expWrite;
  int          expIndex;
  logic [63:0] expBusAddr;
  doubleWord_t expLoad;
  doubleWord_t expMerged;

  memAccessUnit #(
    .AddrWidth(64)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .write       (write),
    .addr        (addr),
    .memOp       (memOp),
    .storeData   (storeData),
    .memReadData (memReadData),
    .loadData    (loadData),
    .done        (done),
    .error       (error),
    .busy        (busy),
    .memAddr     (memAddr),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .memWriteData(memWriteData)
  );

  memoryModel #(
    .AddrWidth(64),
    .Depth    (Depth),
    .Seed     (SeedValue)
  ) memory (
    .clk         (clk),
    .memAddr     (memAddr),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .memWriteData(memWriteData),
    .memReadData (memReadData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  // six cycles per access on average is well above what the whole mix needs
  initial begin
    #(MaxAccesses * 6 * ClockPeriod);
    $display("watchdog expired at %0t before the test sequence finished", $time);
    printCounts();
    $display("FAIL: see errors above");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int accessBytes(input memOp_t op);
    case (op)
      OpByte, OpByteU: accessBytes = 1;
      OpHalf, OpHalfU: accessBytes = 2;
      OpWord, OpWordU: accessBytes = 4;
      default:         accessBytes = 8;
    endcase
  endfunction

  function automatic logic alignFault(input memOp_t op, input int off);
    alignFault = (off % accessBytes(op)) != 0;
  endfunction

  function automatic doubleWord_t loadValue(input doubleWord_t dw, input memOp_t op,
                                            input int off);
    doubleWord_t keep;
    doubleWord_t value;
    int          size;
    logic        zeroExt;
    size    = accessBytes(op);
    zeroExt = (op == OpByteU) || (op == OpHalfU) || (op == OpWordU);
    value   = dw >> (8 * off);
    if (size < 8) begin
      keep  = (64'd1 << (8 * size)) - 64'd1;
      value = value & keep;
      if (!zeroExt && value[8 * size - 1]) begin
        value = value | ~keep;  // copy the lane's top bit upward
      end
    end
    loadValue = value;
  endfunction

  function automatic doubleWord_t storeValue(input doubleWord_t old, input doubleWord_t data,
                                             input memOp_t op, input int off);
    doubleWord_t result;
    int          k;
    result = old;
    for (k = 0; k < accessBytes(op); k++) begin
      if (off + k < 8) begin
        result[8 * (off + k) +: 8] = data[8 * k +: 8];
      end
    end
    storeValue = result;
  endfunction

  function automatic doubleWord_t randomDouble();
    logic [31:0] upper;
    logic [31:0] lower;
    upper        = $random(seed);
    lower        = $random(seed);
    randomDouble = {upper, lower};
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    assert (actual === expected) else begin
      valueErrors++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic printCounts();
    $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the monitor sees the values that were stable just before each rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    logic wasBusy;
    int   age;
    wasBusy   = inFlight;
    edgeCount = edgeCount + 1;
    if (prevReset) begin
      checkValue("memRead", 0, memRead);
      checkValue("memWrite", 0, memWrite);
      checkValue("done", 0, done);
      checkValue("error", 0, error);
      checkValue("busy", 0, busy);
      checkValue("loadData", 0, loadData);
    end else if (!reset && inFlight) begin
      age = edgeCount - acceptEdge;
      checkValue("busy", 1, busy);
      checkValue("done", age == expLatency + 1, done);
      checkValue("error", expFault && age == expLatency + 1, error);
      checkValue("memRead", !expFault && age == 2, memRead);
      checkValue("memWrite", !expFault && expWrite && age == 4, memWrite);
      if (memRead || memWrite) begin
        checkValue("memAddr", expBusAddr, memAddr);
      end
      if (memWrite) begin
        checkValue("memWriteData", expMerged, memWriteData);
      end
      if (age == expLatency + 1) begin
        if (!expFault && !expWrite) begin
          checkValue("loadData", expLoad, loadData);
        end
        if (!expFault && expWrite) begin
          shadow[expIndex] = expMerged;
        end
        inFlight = 1'b0;
      end
    end else if (!reset) begin
      checkValue("busy", 0, busy);  // nothing in flight means no strobe of any kind
      checkValue("done", 0, done);
      checkValue("error", 0, error);
      checkValue("memRead", 0, memRead);
      checkValue("memWrite", 0, memWrite);
    end
    // a start only counts when the unit was idle before this edge
    if (!reset && start && !wasBusy) begin
      inFlight   = 1'b1;
      acceptEdge = edgeCount;
      expIndex   = addr[7:3];
      expFault   = alignFault(memOp, addr[2:0]);
      expWrite   = write;
      expLatency = expFault ? 1 : (write ? 4 : 3);
      expBusAddr = addr & ~64'h7;
      expLoad    = loadValue(shadow[expIndex], memOp, addr[2:0]);
      expMerged  = storeValue(shadow[expIndex], storeData, memOp, addr[2:0]);
    end
    prevReset = reset;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus driven on falling edges
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic runAccess(input logic isWrite, input logic [63:0] address, input memOp_t op,
                           input doubleWord_t value, input logic pokeBusy);
    int waited;
    @(negedge clk);
    start     = 1'b1;
    write     = isWrite;
    addr      = address;
    memOp     = op;
    storeData = value;
    @(negedge clk);
    start = pokeBusy;  // a second start while busy must be dropped
    if (pokeBusy) begin
      write     = 1'b1;
      addr      = {$random(seed)} % (Depth * 8) & ~64'd7;
      memOp     = OpDouble;
      storeData = randomDouble();
    end
    waited = 0;
    while (done !== 1'b1 && waited < DoneLimit) begin
      @(negedge clk);
      start = 1'b0;
      waited++;
    end
    if (done !== 1'b1) begin
      otherErrors++;
      $display("no done within %0d cycles for the access at address %h", DoneLimit, address);
    end else if (pokeBusy) begin
      start = 1'b1;  // the done cycle still counts as busy
      @(negedge clk);
    end
    start = 1'b0;
  endtask

  initial begin
    int          n;
    int          off;
    logic [63:0] base;
    seed      = SeedValue;
    reset     = 1'b1;
    start     = 1'b0;
    write     = 1'b0;
    addr      = '0;
    memOp     = OpByte;
    storeData = '0;
    for (n = 0; n < Depth; n++) begin
      shadow[n] = randomDouble();
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);

    // every code at every aligned offset as a load, a store and a readback
    for (n = 0; n < 7; n++) begin
      for (off = 0; off < 8; off += accessBytes(opList[n])) begin
        base = ({$random(seed)} % Depth) * 8;
        runAccess(1'b0, base + off, opList[n], '0, 1'b0);
        runAccess(1'b1, base + off, opList[n], randomDouble(), 1'b0);
        runAccess(1'b0, base, OpDouble, '0, 1'b0);
      end
    end

    // misaligned loads and stores
    for (n = 0; n < 7; n++) begin
      for (off = 1; off < 8; off++) begin
        if (alignFault(opList[n], off)) begin
          base = ({$random(seed)} % Depth) * 8;
          runAccess(1'b0, base + off, opList[n], '0, 1'b0);
          runAccess(1'b1, base + off, opList[n], randomDouble(), 1'b0);
        end
      end
    end

    // random mix where some accesses get extra starts while busy
    for (n = 0; n < 120; n++) begin
      base = ({$random(seed)} % Depth) * 8;
      off  = {$random(seed)} % 8;
      runAccess($random(seed), base + off, opList[{$random(seed)} % 7], randomDouble(),
                ({$random(seed)} % 3) == 0);
    end

    repeat (3) @(negedge clk);
    printCounts();
    if (valueErrors + otherErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* testbench/memoryModel.sv */
`timescale 1ns/100ps

module memoryModel #(
  parameter int AddrWidth = 64,
  parameter int Depth     = 32,
  parameter int Seed      = 32'hc3a9
) (
  input  logic                 clk,
  input  logic [AddrWidth-1:0] memAddr,
  input  logic                 memRead,
  input  logic                 memWrite,
  input  dataPkg::doubleWord_t memWriteData,
  output dataPkg::doubleWord_t memReadData
);

  localparam int IndexBits = $clog2(Depth);

  logic [63:0]          cells [Depth];
  logic [IndexBits-1:0] index;

  assign index = memAddr[IndexBits+2:3];  // doubleword index, offset bits are zero on this bus

  // same random stream as the shadow copy in the testbench, upper half first
  initial begin
    integer      fillSeed;
    logic [31:0] upper;
    logic [31:0] lower;
    int          i;
    fillSeed = Seed;
    for (i = 0; i < Depth; i++) begin
      upper = $random(fillSeed);
      lower = $random(fillSeed);
      cells[i] = {upper, lower};
    end
    memReadData = '0;
  end

  always @(posedge clk) begin
    if (memRead) begin
      memReadData <= cells[index];  // valid in the cycle after the strobe
    end
    if (memWrite) begin
      cells[index] <= memWriteData;
    end
  end

endmodule
